// ==== Makefile ====
SRCS := $(wildcard design/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_uart_cmd_master
	./obj_dir/Vtb_uart_cmd_master

obj_dir/Vtb_uart_cmd_master: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_uart_cmd_master -f filelist.f

clean:
	rm -rf obj_dir

// ==== design/uart_byte_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface uart_byte_if import uart_pkg::*; ();

  byte_t data;
  logic  start;       // one-cycle request
  logic  busy;
  logic  done;        // one-cycle, in the cycle busy falls
  logic  parity_err;  // valid with done

  modport ctrl   (output data, start, input busy, done, parity_err);
  modport tx_phy (input data, start, output busy, done);
  modport rx_phy (input start, output data, busy, done, parity_err);

endinterface

`default_nettype wire

// ==== design/uart_cmd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_ctrl import uart_pkg::*; #(
  parameter int BAUD_DIV = 434
) (
  input  logic      clk,
  input  logic      rst_n,
  input  cmd_t      cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output byte_t     read_data,
  output logic      read_rdy,
  output logic      read_err,
  uart_byte_if.ctrl tx_bus,
  uart_byte_if.ctrl rx_bus
);

  localparam int GAP_CYCLES = GAP_BITS * BAUD_DIV;
  localparam int GAP_W      = $clog2(GAP_CYCLES + 1);

  ctrl_state_t      state;
  cmd_t             cmd_q;
  addr_t            cmd_addr;
  logic             launched;               // start already issued in this state
  logic [GAP_W-1:0] gap_cnt;
  logic             accept;

  assign cmd_rdy  = (state == IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign cmd_addr = cmd_q[14:8];

  // held steady while the serializer loads it on start
  assign tx_bus.data = (state == SEND_DATA) ? cmd_q[7:0] : {cmd_q[15], cmd_addr};

  // ****************************************
  // transaction sequencing
  // ****************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= IDLE;
      launched     <= 1'b0;
      gap_cnt      <= '0;
      tx_bus.start <= 1'b0;
      rx_bus.start <= 1'b0;
      read_rdy     <= 1'b0;
      read_err     <= 1'b0;
    end
    else
    begin
      tx_bus.start <= 1'b0;
      rx_bus.start <= 1'b0;
      read_rdy     <= 1'b0;
      case (state)
        IDLE:
        begin
          launched <= 1'b0;
          if (accept)
            state <= SEND_CMD;
        end
        SEND_CMD, SEND_DATA:
        begin
          if (!launched)
          begin
            tx_bus.start <= 1'b1;
            launched     <= 1'b1;
          end
          else if (tx_bus.done)
          begin
            launched <= 1'b0;
            if (state == SEND_DATA)
              state <= DONE;
            else if (cmd_q[15])
            begin
              state   <= GAP;
              gap_cnt <= GAP_W'(GAP_CYCLES - 1);
            end
            else
              state <= WAIT_REPLY;
          end
        end
        GAP:
        begin
          if (gap_cnt == '0)
            state <= SEND_DATA;
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        WAIT_REPLY:
        begin
          if (!launched)
          begin
            rx_bus.start <= 1'b1;            // arm the receiver
            launched     <= 1'b1;
          end
          else if (rx_bus.done)
          begin
            launched <= 1'b0;
            read_rdy <= 1'b1;
            read_err <= rx_bus.parity_err;
            state    <= DONE;
          end
        end
        default:
          state <= IDLE;                     // DONE, one cycle before ready
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (state == WAIT_REPLY && launched && rx_bus.done)
      read_data <= rx_bus.data;
  end

  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy);

  a_tx_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_bus.start |-> !tx_bus.busy);

  a_rx_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    rx_bus.start |-> !rx_bus.busy);

endmodule

`default_nettype wire

// ==== design/uart_cmd_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_master import uart_pkg::*; #(
  parameter int BAUD_DIV = 434              // clock cycles per bit
) (
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  input  logic  rx,
  output logic  tx,
  output logic  cmd_rdy,
  output byte_t read_data,
  output logic  read_rdy,
  output logic  read_err
);

  uart_byte_if tx_bus ();
  uart_byte_if rx_bus ();

  uart_cmd_ctrl #(.BAUD_DIV(BAUD_DIV)) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .tx_bus    (tx_bus.ctrl),
    .rx_bus    (rx_bus.ctrl)
  );

  uart_tx_byte #(.BAUD_DIV(BAUD_DIV)) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tx_bus.tx_phy),
    .tx    (tx)
  );

  uart_rx_byte #(.BAUD_DIV(BAUD_DIV)) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .bus   (rx_bus.rx_phy)
  );

endmodule

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // ****************************************
  // command and frame types
  // ****************************************
  typedef logic [15:0] cmd_t;   // [15] write, [14:8] addr, [7:0] data
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;

  localparam int DATA_BITS = 8; // payload bits per frame
  localparam int GAP_BITS  = 2; // idle bit periods between write bytes

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    GAP,
    SEND_DATA,
    WAIT_REPLY,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/uart_rx_byte.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx_byte import uart_pkg::*; #(
  parameter int BAUD_DIV = 434
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  uart_byte_if.rx_phy bus
);

  localparam int         CNT_W    = $clog2(BAUD_DIV + 1);
  localparam int         HALF     = (BAUD_DIV / 2 > 0) ? BAUD_DIV / 2 : 1;
  localparam logic [3:0] PAR_IDX  = 4'(DATA_BITS + 1);
  localparam logic [3:0] STOP_IDX = 4'(DATA_BITS + 2);

  logic             rx_meta;
  logic             rx_sync;
  logic             hunting;                 // armed, waiting for a low level
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;                 // 0 start, then data, parity, stop
  logic             par_bit;
  logic             sample;

  assign sample = bus.busy && !hunting && (baud_cnt == '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta        <= 1'b1;
      rx_sync        <= 1'b1;
      hunting        <= 1'b0;
      baud_cnt       <= '0;
      bit_idx        <= '0;
      bus.busy       <= 1'b0;
      bus.done       <= 1'b0;
      bus.parity_err <= 1'b0;
    end
    else
    begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      bus.done <= 1'b0;
      if (!bus.busy)
      begin
        if (bus.start)
        begin
          bus.busy <= 1'b1;
          hunting  <= 1'b1;
        end
      end
      else if (hunting)
      begin
        if (!rx_sync)
        begin
          hunting  <= 1'b0;
          baud_cnt <= CNT_W'(HALF - 1);      // land on start-bit middle
          bit_idx  <= '0;
        end
      end
      else if (baud_cnt != '0)
        baud_cnt <= baud_cnt - 1'b1;
      else
      begin
        baud_cnt <= CNT_W'(BAUD_DIV - 1);
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_sync)
          hunting <= 1'b1;                   // glitch, keep hunting
        else if (bit_idx == STOP_IDX)
        begin
          bus.busy       <= 1'b0;
          bus.done       <= 1'b1;
          bus.parity_err <= (par_bit != ^bus.data) || !rx_sync;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= 4'(DATA_BITS))
      bus.data <= {rx_sync, bus.data[DATA_BITS-1:1]};  // lsb arrives first
    if (sample && bit_idx == PAR_IDX)
      par_bit <= rx_sync;
  end

  a_rx_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    bus.done |-> $past(bus.busy));

endmodule

`default_nettype wire

// ==== design/uart_tx_byte.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_byte import uart_pkg::*; #(
  parameter int BAUD_DIV = 434
) (
  input  logic        clk,
  input  logic        rst_n,
  uart_byte_if.tx_phy bus,
  output logic        tx
);

  localparam int FRAME_BITS = DATA_BITS + 3;       // start, data, parity, stop
  localparam int CNT_W      = $clog2(BAUD_DIV + 1);

  logic [CNT_W-1:0]       baud_cnt;
  logic [3:0]             bit_idx;
  logic [DATA_BITS+1:0]   shift_q;                  // stop, parity, data
  logic                   bit_end;

  assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      bus.busy <= 1'b0;
      bus.done <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      bus.done <= 1'b0;
      if (!bus.busy)
      begin
        if (bus.start)
        begin
          tx       <= 1'b0;                         // start bit
          bus.busy <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (!bit_end)
        baud_cnt <= baud_cnt + 1'b1;
      else
      begin
        baud_cnt <= '0;
        if (bit_idx == 4'(FRAME_BITS - 1))
        begin
          tx       <= 1'b1;
          bus.busy <= 1'b0;
          bus.done <= 1'b1;
        end
        else
        begin
          tx      <= shift_q[0];
          bit_idx <= bit_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus.start && !bus.busy)
      shift_q <= {1'b1, ^bus.data, bus.data};       // even parity
    else if (bus.busy && bit_end)
      shift_q <= shift_q >> 1;
  end

  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !bus.busy |-> tx);

endmodule

`default_nettype wire

// ==== filelist.f ====
design/uart_pkg.sv
design/uart_byte_if.sv
design/uart_tx_byte.sv
design/uart_rx_byte.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_master.sv
testbench/tb_clk_gen.sv
testbench/tb_uart_slave.sv
testbench/tb_uart_cmd_master.sv

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                        // released between active edges
  end

endmodule

`default_nettype wire

// ==== testbench/tb_uart_cmd_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart_cmd_master import uart_pkg::*; ();

  localparam int BAUD_DIV = 8;
  localparam int NUM_CMDS = 40;
  localparam int TIMEOUT  = NUM_CMDS * 40 * BAUD_DIV + 1000;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  rx;
  logic  tx;
  logic  cmd_rdy;
  byte_t read_data;
  logic  read_rdy;
  logic  read_err;
  logic  corrupt_reply;
  logic  frame_vld;
  byte_t frame_byte;
  logic  frame_par;
  logic  frame_stop;
  int    frame_gap;

  byte_t mirror [128];
  byte_t exp_frame_q [$];
  bit    exp_gap_q [$];                  // frame must follow a write gap
  byte_t exp_rdata_q [$];
  logic  exp_rerr_q [$];
  byte_t exp_byte;
  bit    exp_gap_chk;
  int    frame_cnt  = 0;
  int    read_cnt   = 0;
  int    exp_frames = 0;
  int    exp_reads  = 0;
  int    cycle_cnt  = 0;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clk (.clk(clk), .rst_n(rst_n));

  tb_uart_slave #(.BAUD_DIV(BAUD_DIV)) u_slave (
    .clk(clk), .rst_n(rst_n), .tx(tx), .corrupt(corrupt_reply), .rx(rx),
    .frame_vld(frame_vld), .frame_byte(frame_byte), .frame_par(frame_par),
    .frame_stop(frame_stop), .frame_gap(frame_gap)
  );

  uart_cmd_master #(.BAUD_DIV(BAUD_DIV)) DUT (
    .clk(clk), .rst_n(rst_n), .cmd_in(cmd_in), .cmd_vld(cmd_vld), .rx(rx), .tx(tx),
    .cmd_rdy(cmd_rdy), .read_data(read_data), .read_rdy(read_rdy), .read_err(read_err)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  function automatic byte_t fill_byte(input addr_t a);
    return {a, a[6]} ^ 8'hc3;
  endfunction

  // expected frames, read data and error from one command
  function automatic void predict_command(input cmd_t cmd, input logic corrupt,
                                          output byte_t first, output byte_t second,
                                          output int frames, output byte_t rdata,
                                          output logic rerr);
    first  = {cmd[15], cmd[14:8]};
    second = cmd[7:0];
    frames = cmd[15] ? 2 : 1;
    rdata  = mirror[cmd[14:8]];
    rerr   = !cmd[15] && corrupt;
  endfunction

  task automatic issue_command(input cmd_t cmd, input logic bad);
    while (!cmd_rdy)
      @(negedge clk);
    cmd_in        = cmd;
    corrupt_reply = bad;
    cmd_vld       = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    while (!cmd_rdy)
    begin
      if (($urandom & 15) == 0)
      begin
        cmd_in  = cmd_t'($urandom);      // stray request, must be ignored
        cmd_vld = 1'b1;
      end
      @(negedge clk);
      cmd_vld = 1'b0;
    end
  endtask

  // ****************************************
  // compare processes
  // ****************************************
  always @(posedge clk)
  begin
    if (frame_vld)
    begin
      if (exp_frame_q.size() == 0)
        abort_run("a frame appeared on tx that no accepted command explains");
      else
      begin
        exp_byte    = exp_frame_q.pop_front();
        exp_gap_chk = exp_gap_q.pop_front();
        compare_value("frame_byte", 32'(frame_byte), 32'(exp_byte));
        compare_value("frame_parity", 32'(frame_par), 32'(^exp_byte));
        compare_value("frame_stop", 32'(frame_stop), 32'd1);
        if (exp_gap_chk && frame_gap < GAP_BITS * BAUD_DIV)
          abort_run($sformatf("write gap of %0d cycles is too short", frame_gap));
        frame_cnt++;
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      if (exp_rdata_q.size() == 0)
        abort_run("read_rdy pulsed with no read outstanding");
      else
      begin
        compare_value("read_data", 32'(read_data), 32'(exp_rdata_q.pop_front()));
        compare_value("read_err", 32'(read_err), 32'(exp_rerr_q.pop_front()));
        read_cnt++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT)
      abort_run("timeout, the DUT stopped making progress");
  end

  initial
  begin : stimulus
    cmd_t  cmd;
    int    kind;
    byte_t b0;
    byte_t b1;
    int    nf;
    byte_t rd;
    logic  re;
    void'($urandom(65));
    cmd_in        = '0;
    cmd_vld       = 1'b0;
    corrupt_reply = 1'b0;
    for (int a = 0; a < 128; a++)
      mirror[a] = fill_byte(addr_t'(a));
    wait (rst_n === 1'b1);
    @(negedge clk);
    compare_value("tx", 32'(tx), 32'd1);
    compare_value("cmd_rdy", 32'(cmd_rdy), 32'd1);
    compare_value("read_rdy", 32'(read_rdy), 32'd0);
    compare_value("read_err", 32'(read_err), 32'd0);
    for (int n = 0; n < NUM_CMDS; n++)
    begin
      kind = $urandom_range(2, 0);       // write, read, corrupted read
      cmd  = {kind == 0, 7'($urandom), 8'($urandom)};
      predict_command(cmd, kind == 2, b0, b1, nf, rd, re);
      exp_frame_q.push_back(b0);
      exp_gap_q.push_back(1'b0);
      if (nf == 2)
      begin
        exp_frame_q.push_back(b1);
        exp_gap_q.push_back(1'b1);
        mirror[cmd[14:8]] = cmd[7:0];
      end
      else
      begin
        exp_rdata_q.push_back(rd);
        exp_rerr_q.push_back(re);
        exp_reads++;
      end
      exp_frames += nf;
      issue_command(cmd, kind == 2);
    end
    repeat (4 * BAUD_DIV) @(negedge clk);
    compare_value("frame_count", 32'(frame_cnt), 32'(exp_frames));
    compare_value("read_count", 32'(read_cnt), 32'(exp_reads));
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_uart_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart_slave import uart_pkg::*; #(
  parameter int BAUD_DIV = 8
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx,
  input  logic  corrupt,                 // invert parity of the next reply
  output logic  rx,
  output logic  frame_vld,               // one-cycle pulse between falling edges
  output byte_t frame_byte,
  output logic  frame_par,
  output logic  frame_stop,
  output int    frame_gap                // idle cycles before this frame
);

  byte_t mem [128];

  function automatic byte_t fill_byte(input addr_t a);
    return {a, a[6]} ^ 8'hc3;
  endfunction

  // ****************************************
  // frame decode on falling edges
  // ****************************************
  task automatic receive_frame(output byte_t b, output logic par, output logic stp,
                               output int run);
    logic found;
    found = 1'b0;
    run   = 0;
    while (!found)
    begin
      @(negedge clk);
      if (!rst_n)
        run = 0;
      else if (tx)
        run++;
      else
      begin
        repeat (BAUD_DIV / 2) @(negedge clk);
        found = !tx;                     // start bit still low at its middle
      end
    end
    for (int i = 0; i < DATA_BITS; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      b[i] = tx;                         // lsb first
    end
    repeat (BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (BAUD_DIV) @(negedge clk);
    stp = tx;
  endtask

  task automatic send_reply(input byte_t d);
    repeat (3 * BAUD_DIV) @(negedge clk);
    rx = 1'b0;
    repeat (BAUD_DIV) @(negedge clk);
    for (int i = 0; i < DATA_BITS; i++)
    begin
      rx = d[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rx = (^d) ^ corrupt;
    repeat (BAUD_DIV) @(negedge clk);
    rx = 1'b1;                           // stop bit runs into idle
  endtask

  initial
  begin : serve
    byte_t b;
    logic  par;
    logic  stp;
    int    run;
    logic  wr_pending;
    addr_t wr_addr;
    rx         = 1'b1;
    frame_vld  = 1'b0;
    frame_byte = '0;
    frame_par  = 1'b0;
    frame_stop = 1'b0;
    frame_gap  = 0;
    wr_pending = 1'b0;
    wr_addr    = '0;
    for (int a = 0; a < 128; a++)
      mem[a] = fill_byte(addr_t'(a));
    forever
    begin
      receive_frame(b, par, stp, run);
      frame_byte = b;
      frame_par  = par;
      frame_stop = stp;
      frame_gap  = run - (BAUD_DIV / 2 - 2);  // less the stop-bit tail counted in run
      frame_vld  = 1'b1;
      @(negedge clk);
      frame_vld  = 1'b0;
      if (wr_pending)
      begin
        mem[wr_addr] = b;
        wr_pending   = 1'b0;
      end
      else if (b[7])
      begin
        wr_pending = 1'b1;
        wr_addr    = b[6:0];
      end
      else
        send_reply(mem[b[6:0]]);
    end
  end

endmodule

`default_nettype wire
